// ==== src/csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data and address widths
`define CSR_DATA_W      32
`define CSR_NUM_W       14

// interrupt lines and status fields
`define CSR_HW_INT_N    8
`define CSR_IS_W        13

// ECFG.LIE bit 10 is reserved
`define CSR_LIE_MASK    13'h1bff

// counter value while the timer is stopped
`define CSR_TIMER_IDLE  {`CSR_DATA_W{1'b1}}

`endif

// ==== src/csr_pkg.sv ====
`include "csr_config.svh"

package csr_pkg;

    // CSR numbers that this file implements
    typedef enum logic [`CSR_NUM_W-1:0] {
        csr_crmd   = 14'h00,
        csr_prmd   = 14'h01,
        csr_ecfg   = 14'h04,
        csr_estat  = 14'h05,
        csr_era    = 14'h06,
        csr_badv   = 14'h07,
        csr_eentry = 14'h0c,
        csr_save0  = 14'h30,
        csr_save1  = 14'h31,
        csr_save2  = 14'h32,
        csr_save3  = 14'h33,
        csr_tid    = 14'h40,
        csr_tcfg   = 14'h41,
        csr_tval   = 14'h42,
        csr_ticlr  = 14'h44
    } csr_addr_e;

    typedef enum logic [5:0] {
        ecode_ade = 6'h08,   // address error
        ecode_ale = 6'h09    // misaligned access
    } ecode_e;

    parameter logic [7:0] esubcode_adef = 8'd0;

    // one software access from the pipeline
    typedef struct packed {
        logic                   we;
        csr_addr_e              num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_write_t;

    // exception or ertn leaving write-back
    typedef struct packed {
        logic                   ex;
        logic                   ertn;
        ecode_e                 ecode;
        logic [7:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_commit_t;

    typedef struct packed {
        logic [1:0]             plv;
        logic                   ie;
        logic [1:0]             pplv;
        logic                   pie;
        logic [`CSR_IS_W-1:0]   lie;
        logic [`CSR_IS_W-1:0]   is;
        ecode_e                 ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] badv;
    } exc_fields_t;

    typedef struct packed {
        logic                   en;
        logic                   periodic;
        logic [28:0]            initval;
        logic [`CSR_DATA_W-1:0] tval;
    } timer_fields_t;

    typedef struct packed {
        logic [25:0]                  eentry_va;
        logic [3:0][`CSR_DATA_W-1:0]  save;
        logic [`CSR_DATA_W-1:0]       tid;
    } entry_save_fields_t;

    // masked bits from the write, the rest kept from the old value
    function automatic logic [`CSR_DATA_W-1:0] csr_merge(
        input logic [`CSR_DATA_W-1:0] old,
        input csr_write_t             wr
    );
        return (wr.wvalue & wr.wmask) | (old & ~wr.wmask);
    endfunction

endpackage

// ==== src/csr_exception_regs.sv ====
`include "csr_config.svh"

module csr_exception_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_write_t      csr_wr,
    input  csr_pkg::exc_commit_t     exc,
    input  logic [`CSR_HW_INT_N-1:0] hw_int,
    input  logic                     ipi_int,
    input  logic                     ti_pending,
    output csr_pkg::exc_fields_t     fields,
    output logic                     int_req
);

    logic [1:0]               plv;
    logic                     ie;
    logic [1:0]               pplv;
    logic                     pie;
    logic [`CSR_IS_W-1:0]     lie;
    logic [1:0]               is_sw;
    logic [`CSR_HW_INT_N-1:0] hw_q;
    logic                     ipi_q;
    logic [`CSR_IS_W-1:0]     is_all;
    csr_pkg::ecode_e          ecode;
    logic [8:0]               esubcode;
    logic [`CSR_DATA_W-1:0]   era;
    logic [`CSR_DATA_W-1:0]   badv;

    logic [`CSR_DATA_W-1:0]   crmd_nv;
    logic [`CSR_DATA_W-1:0]   prmd_nv;
    logic [`CSR_DATA_W-1:0]   ecfg_nv;
    logic [`CSR_DATA_W-1:0]   estat_nv;
    logic                     addr_err;
    logic                     badv_from_pc;

    assign crmd_nv  = csr_pkg::csr_merge({29'b0, ie, plv}, csr_wr);
    assign prmd_nv  = csr_pkg::csr_merge({29'b0, pie, pplv}, csr_wr);
    assign ecfg_nv  = csr_pkg::csr_merge({19'b0, lie}, csr_wr);
    assign estat_nv = csr_pkg::csr_merge({30'b0, is_sw}, csr_wr);

    assign addr_err     = exc.ecode == csr_pkg::ecode_ade || exc.ecode == csr_pkg::ecode_ale;
    assign badv_from_pc = exc.ecode == csr_pkg::ecode_ade &&
                          exc.esubcode == csr_pkg::esubcode_adef;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            plv   <= 2'b0;
            ie    <= 1'b0;
            pplv  <= 2'b0;
            pie   <= 1'b0;
            lie   <= '0;
            is_sw <= 2'b0;
            hw_q  <= '0;
            ipi_q <= 1'b0;
        end
        else
        begin
            if (exc.ex)
            begin
                plv  <= 2'b0;                        // enter kernel, interrupts off
                ie   <= 1'b0;
                pplv <= plv;
                pie  <= ie;
            end
            else
            begin
                if (exc.ertn)
                begin
                    plv <= pplv;
                    ie  <= pie;
                end
                else if (csr_wr.we && csr_wr.num == csr_pkg::csr_crmd)
                begin
                    plv <= crmd_nv[1:0];
                    ie  <= crmd_nv[2];
                end
                if (csr_wr.we && csr_wr.num == csr_pkg::csr_prmd)
                begin
                    pplv <= prmd_nv[1:0];
                    pie  <= prmd_nv[2];
                end
            end
            if (csr_wr.we && csr_wr.num == csr_pkg::csr_ecfg)
                lie <= ecfg_nv[`CSR_IS_W-1:0] & `CSR_LIE_MASK;
            if (csr_wr.we && csr_wr.num == csr_pkg::csr_estat)
                is_sw <= estat_nv[1:0];              // only the soft interrupt bits
            hw_q  <= hw_int;
            ipi_q <= ipi_int;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exc.ex)
        begin
            ecode    <= exc.ecode;
            esubcode <= {1'b0, exc.esubcode};
            era      <= exc.pc;
        end
        else if (csr_wr.we && csr_wr.num == csr_pkg::csr_era)
            era <= csr_pkg::csr_merge(era, csr_wr);

        if (exc.ex && addr_err)
            badv <= badv_from_pc ? exc.pc : exc.vaddr;   // fetch fault keeps the pc
        else if (csr_wr.we && csr_wr.num == csr_pkg::csr_badv)
            badv <= csr_pkg::csr_merge(badv, csr_wr);
    end

    assign is_all  = {ipi_q, ti_pending, 1'b0, hw_q, is_sw};
    assign int_req = ie & (|(is_all & lie));

    assign fields = '{plv: plv, ie: ie, pplv: pplv, pie: pie, lie: lie, is: is_all,
                      ecode: ecode, esubcode: esubcode, era: era, badv: badv};

endmodule

// ==== src/csr_timer.sv ====
`include "csr_config.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_write_t    csr_wr,
    output csr_pkg::timer_fields_t fields,
    output logic                   ti_pending
);

    logic                   en;
    logic                   periodic;
    logic [28:0]            initval;
    logic [`CSR_DATA_W-1:0] cnt;
    logic [`CSR_DATA_W-1:0] tcfg_nv;
    logic                   tcfg_we;
    logic                   ticlr_hit;
    logic                   cnt_zero;

    // next TCFG value, so a write can start the counter at the same edge
    assign tcfg_nv = csr_pkg::csr_merge({1'b0, initval, periodic, en}, csr_wr);
    assign tcfg_we = csr_wr.we && csr_wr.num == csr_pkg::csr_tcfg;

    assign ticlr_hit = csr_wr.we && csr_wr.num == csr_pkg::csr_ticlr &&
                       csr_wr.wmask[0] && csr_wr.wvalue[0];
    assign cnt_zero  = cnt == '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
        end
        else if (tcfg_we)
        begin
            en       <= tcfg_nv[0];
            periodic <= tcfg_nv[1];
            initval  <= tcfg_nv[30:2];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            cnt <= `CSR_TIMER_IDLE;
        else if (tcfg_we && tcfg_nv[0])
            cnt <= {tcfg_nv[30:2], 2'b00};            // start with initval x4
        else if (en && cnt != `CSR_TIMER_IDLE)
        begin
            if (cnt_zero && periodic)
                cnt <= {initval, 2'b00};
            else
                cnt <= cnt - 1'b1;                   // one-shot wraps to idle
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ti_pending <= 1'b0;
        else if (en && cnt_zero)
            ti_pending <= 1'b1;                      // expiry beats a clear
        else if (ticlr_hit)
            ti_pending <= 1'b0;
    end

    assign fields = '{en: en, periodic: periodic, initval: initval, tval: cnt};

endmodule

// ==== src/csr_entry_save_regs.sv ====
`include "csr_config.svh"

module csr_entry_save_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_write_t         csr_wr,
    input  logic [`CSR_DATA_W-1:0]      coreid,
    output csr_pkg::entry_save_fields_t fields
);

    logic [25:0]                 eentry_va;
    logic [3:0][`CSR_DATA_W-1:0] save;
    logic [`CSR_DATA_W-1:0]      tid;
    logic [`CSR_DATA_W-1:0]      eentry_nv;
    logic [3:0]                  save_we;

    assign eentry_nv = csr_pkg::csr_merge({eentry_va, 6'b0}, csr_wr);

    // each scratch word decodes its own number
    assign save_we[0] = csr_wr.we && csr_wr.num == csr_pkg::csr_save0;
    assign save_we[1] = csr_wr.we && csr_wr.num == csr_pkg::csr_save1;
    assign save_we[2] = csr_wr.we && csr_wr.num == csr_pkg::csr_save2;
    assign save_we[3] = csr_wr.we && csr_wr.num == csr_pkg::csr_save3;

    always_ff @(posedge clk)
    begin
        if (csr_wr.we && csr_wr.num == csr_pkg::csr_eentry)
            eentry_va <= eentry_nv[31:6];             // entry is 64-byte aligned
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (save_we[i])
                save[i] <= csr_pkg::csr_merge(save[i], csr_wr);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tid <= coreid;
        else if (csr_wr.we && csr_wr.num == csr_pkg::csr_tid)
            tid <= csr_pkg::csr_merge(tid, csr_wr);
    end

    assign fields = '{eentry_va: eentry_va, save: save, tid: tid};

endmodule

// ==== src/csr_read_mux.sv ====
`include "csr_config.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e          num,
    input  csr_pkg::exc_fields_t        exc_f,
    input  csr_pkg::timer_fields_t      timer_f,
    input  csr_pkg::entry_save_fields_t es_f,
    output logic [`CSR_DATA_W-1:0]      rdata
);

    logic [`CSR_DATA_W-1:0] crmd_rv;
    logic [`CSR_DATA_W-1:0] prmd_rv;
    logic [`CSR_DATA_W-1:0] ecfg_rv;
    logic [`CSR_DATA_W-1:0] estat_rv;
    logic [`CSR_DATA_W-1:0] eentry_rv;
    logic [`CSR_DATA_W-1:0] tcfg_rv;

    // direct address mode, paging off
    assign crmd_rv = {23'b0, 2'b00, 2'b00, 1'b0, 1'b1, exc_f.ie, exc_f.plv};
    assign prmd_rv = {29'b0, exc_f.pie, exc_f.pplv};
    assign ecfg_rv = {19'b0, exc_f.lie};

    assign estat_rv = {1'b0, exc_f.esubcode, exc_f.ecode, 3'b0, exc_f.is};

    assign eentry_rv = {es_f.eentry_va, 6'b0};
    assign tcfg_rv   = {1'b0, timer_f.initval, timer_f.periodic, timer_f.en};

    always_comb
    begin
        case (num)
            csr_pkg::csr_crmd:   rdata = crmd_rv;
            csr_pkg::csr_prmd:   rdata = prmd_rv;
            csr_pkg::csr_ecfg:   rdata = ecfg_rv;
            csr_pkg::csr_estat:  rdata = estat_rv;
            csr_pkg::csr_era:    rdata = exc_f.era;
            csr_pkg::csr_badv:   rdata = exc_f.badv;
            csr_pkg::csr_eentry: rdata = eentry_rv;
            csr_pkg::csr_save0:  rdata = es_f.save[0];
            csr_pkg::csr_save1:  rdata = es_f.save[1];
            csr_pkg::csr_save2:  rdata = es_f.save[2];
            csr_pkg::csr_save3:  rdata = es_f.save[3];
            csr_pkg::csr_tid:    rdata = es_f.tid;
            csr_pkg::csr_tcfg:   rdata = tcfg_rv;
            csr_pkg::csr_tval:   rdata = timer_f.tval;
            default:             rdata = '0;       // ticlr and unknown numbers
        endcase
    end

endmodule

// ==== src/csr_top.sv ====
`include "csr_config.svh"

module csr_top (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_write_t      csr_wr,
    input  csr_pkg::exc_commit_t     exc,
    input  logic [`CSR_HW_INT_N-1:0] hw_int,
    input  logic                     ipi_int,
    input  logic [`CSR_DATA_W-1:0]   coreid,
    output logic [`CSR_DATA_W-1:0]   rdata,
    output logic                     int_req,
    output logic [`CSR_DATA_W-1:0]   era_pc,
    output logic [`CSR_DATA_W-1:0]   eentry
);

    csr_pkg::exc_fields_t        exc_f;
    csr_pkg::timer_fields_t      timer_f;
    csr_pkg::entry_save_fields_t es_f;
    logic                        ti_pending;

    csr_exception_regs u_exc (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .exc        (exc),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .ti_pending (ti_pending),
        .fields     (exc_f),
        .int_req    (int_req)
    );

    csr_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .fields     (timer_f),
        .ti_pending (ti_pending)
    );

    csr_entry_save_regs u_entry_save (
        .clk    (clk),
        .rst    (rst),
        .csr_wr (csr_wr),
        .coreid (coreid),
        .fields (es_f)
    );

    csr_read_mux u_rmux (
        .num     (csr_wr.num),
        .exc_f   (exc_f),
        .timer_f (timer_f),
        .es_f    (es_f),
        .rdata   (rdata)
    );

    // redirect targets for the pipeline
    assign era_pc = exc_f.era;
    assign eentry = {es_f.eentry_va, 6'b0};

endmodule

// ==== testbench/csr_tb.sv ====
`include "csr_config.svh"

module csr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 5;
    localparam int oneshot_init  = 3;
    localparam int periodic_init = 2;
    localparam logic [31:0] core_id = 32'h0000_0005;
    // summed cycle budget of the test groups
    localparam int test_cycles = reset_cycles + 8 + 32 + 24 + (4 * oneshot_init + 10) +
                                 (8 * periodic_init + 12) + 16;

    logic                     clk;
    logic                     rst;
    csr_pkg::csr_write_t      csr_wr;
    csr_pkg::exc_commit_t     exc;
    logic [`CSR_HW_INT_N-1:0] hw_int;
    logic                     ipi_int;
    logic [`CSR_DATA_W-1:0]   coreid;
    logic [`CSR_DATA_W-1:0]   rdata;
    logic                     int_req;
    logic [`CSR_DATA_W-1:0]   era_pc;
    logic [`CSR_DATA_W-1:0]   eentry;

    integer                   seed;
    logic [1:0]               m_plv;
    logic                     m_ie;
    logic [1:0]               m_pplv;
    logic                     m_pie;
    logic [`CSR_IS_W-1:0]     m_lie;
    logic [1:0]               m_sw;
    logic [7:0]               m_hw;
    logic                     m_ipi;
    logic                     m_ti;
    logic [5:0]               m_ecode;
    logic [8:0]               m_esub;
    logic [31:0]              m_era;
    logic [31:0]              m_badv;
    logic [31:0]              m_eentry;
    logic [31:0]              m_tid;
    logic [31:0]              m_save [4];

    csr_top UUT (
        .clk     (clk),
        .rst     (rst),
        .csr_wr  (csr_wr),
        .exc     (exc),
        .hw_int  (hw_int),
        .ipi_int (ipi_int),
        .coreid  (coreid),
        .rdata   (rdata),
        .int_req (int_req),
        .era_pc  (era_pc),
        .eentry  (eentry)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] merge_bits(input logic [31:0] old,
                                               input logic [31:0] value,
                                               input logic [31:0] mask);
        return (value & mask) | (old & ~mask);
    endfunction

    function automatic logic [`CSR_IS_W-1:0] is_model();
        return {m_ipi, m_ti, 1'b0, m_hw, m_sw};
    endfunction

    // DA reads 1, PG reads 0
    function automatic logic [31:0] crmd_model();
        return {28'b0, 1'b1, m_ie, m_plv};
    endfunction

    function automatic logic [31:0] estat_model();
        return {1'b0, m_esub, m_ecode, 3'b0, is_model()};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // sample mid-cycle and return just after the next edge
    task automatic read_expect(input csr_pkg::csr_addr_e n, input logic [31:0] expected,
                               input string name);
        csr_wr.we  = 1'b0;
        csr_wr.num = n;
        #10;
        check_value(name, expected, rdata);
        check_value({name, "_int_req"}, {31'b0, m_ie & (|(is_model() & m_lie))}, {31'b0, int_req});
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_e n, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_wr.we     = 1'b1;
        csr_wr.num    = n;
        csr_wr.wmask  = mask;
        csr_wr.wvalue = value;
        @(posedge clk);
        #2;
        csr_wr.we = 1'b0;
    endtask

    task automatic commit_exception(input csr_pkg::ecode_e code, input logic [7:0] sub,
                                    input logic [31:0] pc, input logic [31:0] vaddr);
        exc.ex       = 1'b1;
        exc.ecode    = code;
        exc.esubcode = sub;
        exc.pc       = pc;
        exc.vaddr    = vaddr;
        @(posedge clk);
        #2;
        exc.ex  = 1'b0;
        m_pplv  = m_plv;
        m_pie   = m_ie;
        m_plv   = 2'd0;
        m_ie    = 1'b0;
        m_era   = pc;
        m_ecode = code;
        m_esub  = {1'b0, sub};
        if (code == csr_pkg::ecode_ade && sub == csr_pkg::esubcode_adef)
            m_badv = pc;                 // fetch fault
        else
            m_badv = vaddr;
    endtask

    initial
    begin
        #(test_cycles * clk_period * 3 / 2);
        $display("Timeout: tests still running after %0d cycles", test_cycles * 3 / 2);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] merged;

        seed     = 32'h222b_2a38;
        clk      = 1'b0;
        rst      = 1'b1;
        csr_wr   = '0;
        exc      = '0;
        hw_int   = '0;
        ipi_int  = 1'b0;
        coreid   = core_id;
        m_plv    = 2'd0;
        m_ie     = 1'b0;
        m_pplv   = 2'd0;
        m_pie    = 1'b0;
        m_lie    = '0;
        m_sw     = 2'b00;
        m_hw     = '0;
        m_ipi    = 1'b0;
        m_ti     = 1'b0;
        m_tid    = core_id;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;

        read_expect(csr_pkg::csr_crmd, 32'h8, "reset_crmd");
        read_expect(csr_pkg::csr_tid, core_id, "reset_tid");
        read_expect(csr_pkg::csr_ecfg, 32'h0, "reset_ecfg");
        read_expect(csr_pkg::csr_prmd, 32'h0, "reset_prmd");
        read_expect(csr_pkg::csr_tcfg, 32'h0, "reset_tcfg");
        read_expect(csr_pkg::csr_tval, `CSR_TIMER_IDLE, "reset_tval");

        // scratch words get a full write and then a random mask
        for (int i = 0; i < 4; i++)
        begin
            m_save[i] = $random(seed);
            write_csr(csr_pkg::csr_addr_e'(csr_pkg::csr_save0 + i), '1, m_save[i]);
            mask  = $random(seed);
            value = $random(seed);
            write_csr(csr_pkg::csr_addr_e'(csr_pkg::csr_save0 + i), mask, value);
            m_save[i] = merge_bits(m_save[i], value, mask);
        end
        for (int i = 0; i < 4; i++)
            read_expect(csr_pkg::csr_addr_e'(csr_pkg::csr_save0 + i), m_save[i], "save_masked");

        value = $random(seed);
        write_csr(csr_pkg::csr_eentry, '1, value);
        m_eentry = value & ~32'h3f;
        mask     = $random(seed);
        value    = $random(seed);
        write_csr(csr_pkg::csr_eentry, mask, value);
        m_eentry = merge_bits(m_eentry, value, mask) & ~32'h3f;
        read_expect(csr_pkg::csr_eentry, m_eentry, "eentry_masked");
        check_value("eentry_port", m_eentry, eentry);

        mask  = $random(seed);
        value = $random(seed);
        write_csr(csr_pkg::csr_tid, mask, value);
        m_tid = merge_bits(m_tid, value, mask);
        read_expect(csr_pkg::csr_tid, m_tid, "tid_masked");

        write_csr(csr_pkg::csr_ecfg, '1, '1);
        m_lie = `CSR_LIE_MASK;
        read_expect(csr_pkg::csr_ecfg, {19'b0, m_lie}, "ecfg_lie_mask");
        mask  = $random(seed);
        value = $random(seed);
        write_csr(csr_pkg::csr_ecfg, mask, value);
        merged = merge_bits({19'b0, m_lie}, value, mask);
        m_lie  = merged[12:0] & `CSR_LIE_MASK;
        read_expect(csr_pkg::csr_ecfg, {19'b0, m_lie}, "ecfg_masked");

        write_csr(csr_pkg::csr_crmd, 32'h7, 32'h7);
        m_plv = 2'd3;
        m_ie  = 1'b1;
        read_expect(csr_pkg::csr_crmd, crmd_model(), "crmd_plv3_ie");
        csr_wr.we     = 1'b1;            // competing CRMD write loses to the exception
        csr_wr.num    = csr_pkg::csr_crmd;
        csr_wr.wmask  = 32'h7;
        csr_wr.wvalue = 32'h3;
        commit_exception(csr_pkg::ecode_ade, csr_pkg::esubcode_adef, 32'h1c00_0120, 32'h0bad_0004);
        csr_wr.we = 1'b0;
        read_expect(csr_pkg::csr_prmd, {29'b0, m_pie, m_pplv}, "ade_prmd");
        read_expect(csr_pkg::csr_crmd, crmd_model(), "ade_crmd");
        read_expect(csr_pkg::csr_era, m_era, "ade_era");
        read_expect(csr_pkg::csr_badv, m_badv, "ade_badv");
        read_expect(csr_pkg::csr_estat, estat_model(), "ade_estat");
        check_value("ade_era_pc", m_era, era_pc);

        // data-side ADE carries a sub-code and the data address
        commit_exception(csr_pkg::ecode_ade, 8'd1, 32'h1c00_0160, 32'h0bad_0008);
        read_expect(csr_pkg::csr_badv, m_badv, "adem_badv");
        read_expect(csr_pkg::csr_estat, estat_model(), "adem_estat");

        write_csr(csr_pkg::csr_crmd, 32'h7, 32'h7);
        m_plv = 2'd3;
        m_ie  = 1'b1;
        commit_exception(csr_pkg::ecode_ale, 8'd0, 32'h1c00_0200, 32'h0000_7ff3);
        read_expect(csr_pkg::csr_badv, m_badv, "ale_badv");
        read_expect(csr_pkg::csr_estat, estat_model(), "ale_estat");
        read_expect(csr_pkg::csr_era, m_era, "ale_era");
        write_csr(csr_pkg::csr_prmd, 32'h3, 32'h1);
        merged = merge_bits({29'b0, m_pie, m_pplv}, 32'h1, 32'h3);
        m_pplv = merged[1:0];
        m_pie  = merged[2];
        read_expect(csr_pkg::csr_prmd, {29'b0, m_pie, m_pplv}, "prmd_masked");
        exc.ertn = 1'b1;
        @(posedge clk);
        #2;
        exc.ertn = 1'b0;
        m_plv    = m_pplv;
        m_ie     = m_pie;
        read_expect(csr_pkg::csr_crmd, crmd_model(), "ertn_crmd");

        // one-shot TI shows up initval*4+1 edges after the TCFG write edge
        write_csr(csr_pkg::csr_ecfg, '1, '0);
        m_lie = '0;
        write_csr(csr_pkg::csr_tcfg, '1, 32'(oneshot_init * 4 + 1));
        read_expect(csr_pkg::csr_tval, 32'(oneshot_init * 4), "oneshot_tval_load");
        for (int k = 1; k <= 4 * oneshot_init + 1; k++)
        begin
            m_ti = (k == 4 * oneshot_init + 1);
            read_expect(csr_pkg::csr_estat, estat_model(), "oneshot_ti_edge");
        end
        read_expect(csr_pkg::csr_tval, `CSR_TIMER_IDLE, "oneshot_tval_idle");
        write_csr(csr_pkg::csr_ecfg, '1, 32'h0000_0800);
        m_lie = 13'h0800;
        read_expect(csr_pkg::csr_estat, estat_model(), "oneshot_int_req");
        write_csr(csr_pkg::csr_ticlr, 32'h1, 32'h1);
        m_ti = 1'b0;
        read_expect(csr_pkg::csr_estat, estat_model(), "ticlr_clear");

        // periodic mode reloads and raises a second TI one period later
        write_csr(csr_pkg::csr_tcfg, '1, 32'(periodic_init * 4 + 3));
        for (int k = 0; k <= 4 * periodic_init; k++)
            read_expect(csr_pkg::csr_estat, estat_model(), "periodic_count");
        m_ti = 1'b1;
        read_expect(csr_pkg::csr_tval, 32'(periodic_init * 4), "periodic_reload");
        write_csr(csr_pkg::csr_ticlr, 32'h1, 32'h1);
        for (int k = 4 * periodic_init + 3; k <= 8 * periodic_init + 2; k++)
        begin
            m_ti = (k == 8 * periodic_init + 2);
            read_expect(csr_pkg::csr_estat, estat_model(), "periodic_second_ti");
        end
        write_csr(csr_pkg::csr_tcfg, '1, '0);
        write_csr(csr_pkg::csr_ticlr, 32'h1, 32'h1);
        m_ti = 1'b0;
        read_expect(csr_pkg::csr_estat, estat_model(), "timer_stopped");

        // external lines land in ESTAT one edge after they are driven
        hw_int = 8'ha5;
        read_expect(csr_pkg::csr_estat, estat_model(), "hw_before_edge");
        m_hw = 8'ha5;
        read_expect(csr_pkg::csr_estat, estat_model(), "hw_sampled");
        write_csr(csr_pkg::csr_ecfg, '1, 32'h0000_0004);
        m_lie = 13'h0004;
        read_expect(csr_pkg::csr_estat, estat_model(), "hw_enabled");
        ipi_int = 1'b1;
        read_expect(csr_pkg::csr_estat, estat_model(), "ipi_before_edge");
        m_ipi = 1'b1;
        read_expect(csr_pkg::csr_estat, estat_model(), "ipi_sampled");
        write_csr(csr_pkg::csr_ecfg, '1, 32'h0000_1000);
        m_lie = 13'h1000;
        read_expect(csr_pkg::csr_estat, estat_model(), "ipi_enabled");
        write_csr(csr_pkg::csr_estat, '1, 32'hffff_fffe);
        m_sw = 2'b10;                    // only the soft bits take the write
        read_expect(csr_pkg::csr_estat, estat_model(), "estat_soft_write");
        write_csr(csr_pkg::csr_crmd, 32'h4, 32'h0);
        m_ie = 1'b0;
        read_expect(csr_pkg::csr_crmd, crmd_model(), "ie_off");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/csr_pkg.sv
src/csr_exception_regs.sv
src/csr_timer.sv
src/csr_entry_save_regs.sv
src/csr_read_mux.sv
src/csr_top.sv
testbench/csr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module csr_tb \
    -f all.f -o csr_sim &&
./obj_dir/csr_sim | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null ||
{ echo "csr testbench run did not pass"; exit 1; }
